/* hw/alpha_timing_pkg.sv */
package alpha_timing_pkg;

	// timing defaults, overridden from the top level
	localparam int default_phase_cycles = 100; // clocks per sequence phase
	localparam int default_pickoff_depth = 6; // button pipeline taps

	// serial configuration word
	localparam int config_word_bits = 16;
	localparam int dummy_bits = 4; // extra bits after the word, index wraps
	localparam logic [config_word_bits-1:0] default_config_word = 16'h0a05;

	// reset / sync / token sequencer
	typedef enum logic [2:0] {
		seq_idle,
		seq_lead_in,
		seq_dreset_high,
		seq_dreset_low,
		seq_sync_high,
		seq_sync_low,
		seq_token_high,
		seq_token_low
	} seq_state_t;

	// one bit per setup / high / low triple
	typedef enum logic [2:0] {
		shift_idle,
		shift_lead_in,
		shift_data_setup, // sin takes the next bit
		shift_clock_high,
		shift_clock_low // bit index advances here
	} shift_state_t;

endpackage

/* hw/alpha_link_pkg.sv */
package alpha_link_pkg;

	// raw push button levels from the board
	typedef struct packed {
		logic start_reset_sync; // button 1
		logic start_config; // button 2
	} buttons_t;

	// one-cycle strobes out of the edge detector, same bit order as buttons_t
	typedef struct packed {
		logic reset_sync;
		logic configure;
	} start_strobe_t;

	// sequencer outputs, never high together
	typedef struct packed {
		logic dreset;
		logic sync;
		logic token;
	} sequence_out_t;

	typedef struct packed {
		logic sin;
		logic sclk; // slow bit clock
	} serial_out_t;

	// pins to the readout chip
	typedef struct packed {
		logic pclk_t; // top, middle and bottom copies of the pixel clock
		logic pclk_m;
		logic pclk_b;
		logic sclk;
		logic sin;
		logic sync;
		logic token;
		logic auxtrig;
	} chip_pins_t;

endpackage

/* hw/button_edge_detect.sv */
module button_edge_detect #(
	parameter int pickoff_depth = 6
) (
	input logic clock,
	input logic reset,
	input alpha_link_pkg::buttons_t buttons,
	output alpha_link_pkg::start_strobe_t strobes
);
	// tap 0 samples the pin, taps 1..pickoff_depth form the press window,
	// the oldest tap holds the level from just before the window
	localparam int oldest_tap = pickoff_depth + 1;

	logic [1:0] levels;
	logic [1:0][oldest_tap:0] pipe; // one delay line per button
	logic [1:0] rise;

	assign levels = buttons; // same bit order as the strobe struct

	// low before the window, high across all of it
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			rise[b] = !pipe[b][oldest_tap] && (&pipe[b][pickoff_depth:1]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pipe <= '0;
			strobes <= '0;
		end else begin
			for (int b = 0; b < 2; b++) begin
				pipe[b] <= {pipe[b][pickoff_depth:0], levels[b]}; // shift toward oldest
			end
			// true for a single cycle, the oldest tap goes high next
			strobes <= alpha_link_pkg::start_strobe_t'(rise);
		end
	end

endmodule

/* hw/reset_sync_sequencer.sv */
module reset_sync_sequencer #(
	parameter int phase_cycles = 100
) (
	input logic clock,
	input logic reset,
	input logic start, // one-cycle strobe, restarts at any time
	output alpha_link_pkg::sequence_out_t seq
);
	localparam int count_width = $clog2(phase_cycles + 1);

	alpha_timing_pkg::seq_state_t state;
	alpha_timing_pkg::seq_state_t next_state;
	alpha_link_pkg::sequence_out_t next_seq;
	logic [count_width-1:0] count; // clocks spent in the current phase
	logic phase_done;

	assign phase_done = count == count_width'(phase_cycles - 1);

	// every phase is phase_cycles long, the strobe overrides everything
	always_comb begin
		next_state = state;
		if (start) begin
			next_state = alpha_timing_pkg::seq_lead_in;
		end else if (phase_done) begin
			case (state)
				alpha_timing_pkg::seq_lead_in: next_state = alpha_timing_pkg::seq_dreset_high;
				alpha_timing_pkg::seq_dreset_high: next_state = alpha_timing_pkg::seq_dreset_low;
				alpha_timing_pkg::seq_dreset_low: next_state = alpha_timing_pkg::seq_sync_high;
				alpha_timing_pkg::seq_sync_high: next_state = alpha_timing_pkg::seq_sync_low;
				alpha_timing_pkg::seq_sync_low: next_state = alpha_timing_pkg::seq_token_high;
				alpha_timing_pkg::seq_token_high: next_state = alpha_timing_pkg::seq_token_low;
				alpha_timing_pkg::seq_token_low: next_state = alpha_timing_pkg::seq_idle; // done
				default: next_state = alpha_timing_pkg::seq_idle;
			endcase
		end
	end

	// outputs decoded from the next state, so they switch with the state register
	always_comb begin
		next_seq = '0;
		case (next_state)
			alpha_timing_pkg::seq_dreset_high: next_seq.dreset = 1'b1;
			alpha_timing_pkg::seq_sync_high: next_seq.sync = 1'b1;
			alpha_timing_pkg::seq_token_high: next_seq.token = 1'b1;
			default: next_seq = '0; // lead-in, low phases and idle
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_timing_pkg::seq_idle;
			count <= '0;
			seq <= '0;
		end else begin
			state <= next_state;
			seq <= next_seq; // dreset rises phase_cycles+1 clocks after the strobe
			if (start || phase_done || state == alpha_timing_pkg::seq_idle) begin
				count <= '0; // new phase or parked
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

/* hw/serial_config_shifter.sv */
module serial_config_shifter #(
	parameter int phase_cycles = 100,
	parameter logic [alpha_timing_pkg::config_word_bits-1:0] config_word =
		alpha_timing_pkg::default_config_word
) (
	input logic clock,
	input logic reset,
	input logic start, // one-cycle strobe, restarts the shift
	output alpha_link_pkg::serial_out_t serial
);
	localparam int count_width = $clog2(phase_cycles + 1);
	localparam int index_width = $clog2(alpha_timing_pkg::config_word_bits);
	// word bits plus the dummy tail
	localparam int total_bits = alpha_timing_pkg::config_word_bits + alpha_timing_pkg::dummy_bits;
	localparam int sent_width = $clog2(total_bits + 1);

	alpha_timing_pkg::shift_state_t state;
	logic [count_width-1:0] count; // clocks in the current phase
	logic [index_width-1:0] bit_index; // wraps at 16, so the tail repeats bits 0..3
	logic [sent_width-1:0] bits_sent;
	logic phase_done;

	assign phase_done = count == count_width'(phase_cycles - 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= alpha_timing_pkg::shift_idle;
			count <= '0;
			bit_index <= '0;
			bits_sent <= '0;
			serial <= '0;
		end else if (start) begin
			// restart from the lead-in, lines low
			state <= alpha_timing_pkg::shift_lead_in;
			count <= '0;
			bit_index <= '0;
			bits_sent <= '0;
			serial <= '0;
		end else if (state != alpha_timing_pkg::shift_idle) begin
			if (!phase_done) begin
				count <= count + 1'b1;
			end else begin
				count <= '0;
				case (state)
					alpha_timing_pkg::shift_lead_in: begin
						state <= alpha_timing_pkg::shift_data_setup;
						serial.sin <= config_word[bit_index]; // lsb first
					end
					alpha_timing_pkg::shift_data_setup: begin
						state <= alpha_timing_pkg::shift_clock_high;
						serial.sclk <= 1'b1; // sin held from setup
					end
					alpha_timing_pkg::shift_clock_high: begin
						state <= alpha_timing_pkg::shift_clock_low;
						serial.sclk <= 1'b0;
						bit_index <= bit_index + 1'b1;
						bits_sent <= bits_sent + 1'b1;
					end
					alpha_timing_pkg::shift_clock_low: begin
						if (bits_sent == sent_width'(total_bits)) begin
							// 61 phases in all, sin keeps the last bit
							state <= alpha_timing_pkg::shift_idle;
						end else begin
							state <= alpha_timing_pkg::shift_data_setup;
							serial.sin <= config_word[bit_index];
						end
					end
					default: state <= alpha_timing_pkg::shift_idle;
				endcase
			end
		end
	end

endmodule

/* hw/alpha_control_top.sv */
module alpha_control_top #(
	parameter int phase_cycles = alpha_timing_pkg::default_phase_cycles,
	parameter int pickoff_depth = alpha_timing_pkg::default_pickoff_depth,
	parameter logic [alpha_timing_pkg::config_word_bits-1:0] config_word =
		alpha_timing_pkg::default_config_word
) (
	input logic clock,
	input logic reset,
	input alpha_link_pkg::buttons_t buttons,
	input logic auxtrig_in, // passed through, forced high during dreset
	output alpha_link_pkg::chip_pins_t pins
);
	alpha_link_pkg::start_strobe_t strobes;
	alpha_link_pkg::sequence_out_t seq;
	alpha_link_pkg::serial_out_t serial;

	// buttons to one-cycle starts
	button_edge_detect #(
		.pickoff_depth(pickoff_depth)
	) edge_detect (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.strobes(strobes)
	);

	reset_sync_sequencer #(
		.phase_cycles(phase_cycles)
	) sequencer (
		.clock(clock),
		.reset(reset),
		.start(strobes.reset_sync), // button 1
		.seq(seq)
	);

	serial_config_shifter #(
		.phase_cycles(phase_cycles),
		.config_word(config_word)
	) shifter (
		.clock(clock),
		.reset(reset),
		.start(strobes.configure), // button 2
		.serial(serial)
	);

	// clock-like pins all forced high while dreset is up
	always_comb begin
		pins.pclk_t = seq.dreset; // no pixel clock, only the reset pulse
		pins.pclk_m = seq.dreset;
		pins.pclk_b = seq.dreset;
		pins.sclk = serial.sclk | seq.dreset;
		pins.sin = serial.sin;
		pins.sync = seq.sync;
		pins.token = seq.token;
		pins.auxtrig = auxtrig_in | seq.dreset;
	end

endmodule

/* testbench/alpha_control_properties.sv */
module alpha_control_properties (
	input logic clock,
	input logic reset,
	input alpha_link_pkg::start_strobe_t strobes,
	input alpha_link_pkg::sequence_out_t seq,
	input alpha_link_pkg::serial_out_t serial
);
	int unsigned failures = 0; // read by the testbench before its verdict

	// the three chip pulses take turns
	pulses_exclusive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({seq.dreset, seq.sync, seq.token}))
	else begin
		failures++;
		$error("dreset, sync and token high together: %b", seq);
	end

	// chip samples sin while sclk is up
	sin_stable_in_sclk: assert property (@(posedge clock) disable iff (reset)
		serial.sclk |-> $stable(serial.sin))
	else begin
		failures++;
		$error("sin moved while sclk was high");
	end

	reset_sync_strobe_single: assert property (@(posedge clock) disable iff (reset)
		strobes.reset_sync |=> !strobes.reset_sync)
	else begin
		failures++;
		$error("reset_sync strobe longer than one cycle");
	end

	configure_strobe_single: assert property (@(posedge clock) disable iff (reset)
		strobes.configure |=> !strobes.configure)
	else begin
		failures++;
		$error("configure strobe longer than one cycle");
	end

endmodule

bind alpha_control_top alpha_control_properties props (
	.clock(clock),
	.reset(reset),
	.strobes(strobes),
	.seq(seq),
	.serial(serial)
);

/* testbench/alpha_control_tb.sv */
module alpha_control_tb;

	localparam int phase_cycles = 4;
	localparam int pickoff_depth = 6;
	localparam logic [alpha_timing_pkg::config_word_bits-1:0] config_word =
		alpha_timing_pkg::default_config_word;
	localparam int word_bits = alpha_timing_pkg::config_word_bits;
	localparam int shift_bits = word_bits + alpha_timing_pkg::dummy_bits;
	// press edge to first dreset sample, and to first sclk sample
	localparam int seq_offset = pickoff_depth + phase_cycles + 3;
	localparam int shift_offset = pickoff_depth + 2 * phase_cycles + 3;
	localparam int quiet_cycles = pickoff_depth + 3 + 61 * phase_cycles + 8; // whole shift + slack
	localparam int num_rows = 7;

	typedef struct {
		string name;
		alpha_link_pkg::buttons_t press;
		int hold; // cycles the buttons stay down
		int repress_gap; // low cycles before a second press or 0
		int sequences; // full dreset/sync/token runs expected
		int shifts; // 20-bit shifts expected
	} test_row_t;

	// one finished pulse on the pins
	typedef struct {
		int kind; // 0 dreset, 1 sync, 2 token, 3 sclk
		int start;
		int width;
	} pulse_t;

	typedef struct {
		int at;
		alpha_link_pkg::serial_out_t value;
	} capture_t;

	logic clock = 1'b0;
	logic reset;
	alpha_link_pkg::buttons_t buttons;
	logic auxtrig_in;
	alpha_link_pkg::chip_pins_t pins;

	test_row_t rows [num_rows];
	pulse_t pulses [$];
	capture_t captures [$]; // sin at each sclk rise
	logic [31:0] lfsr = 32'hde964bb1;
	int cycle = 0;
	int cycle_limit = 0;
	logic monitoring = 1'b0;
	logic sclk_free = 1'b1; // sclk pin must follow dreset when no shift runs
	logic [3:0] prev_level = '0;
	int rise_at [4];
	string current_test = "after_reset";

	alpha_control_top #(
		.phase_cycles(phase_cycles),
		.pickoff_depth(pickoff_depth),
		.config_word(config_word)
	) UUT (
		.clock(clock),
		.reset(reset),
		.buttons(buttons),
		.auxtrig_in(auxtrig_in),
		.pins(pins)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // x^32+x^22+x^2+x+1
		return {state[30:0], feedback};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_random(input int bits, output int value);
		value = 0;
		for (int i = 0; i < bits; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic fail_run();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_pins(
		input string name,
		input alpha_link_pkg::chip_pins_t expected,
		input alpha_link_pkg::chip_pins_t actual
	);
		if (expected !== actual) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_sequence(
		input string name,
		input alpha_link_pkg::sequence_out_t expected,
		input alpha_link_pkg::sequence_out_t actual
	);
		if (expected !== actual) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_serial(
		input string name,
		input alpha_link_pkg::serial_out_t expected,
		input alpha_link_pkg::serial_out_t actual
	);
		if (expected !== actual) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	// name, buttons, hold, repress gap, sequences, shifts
	task automatic load_rows();
		rows[0] = '{"seq_press", 2'b10, 10, 0, 1, 0};
		rows[1] = '{"config_shift", 2'b01, 10, 0, 0, 1};
		rows[2] = '{"short_press_seq", 2'b10, 3, 0, 0, 0}; // under the pipeline depth
		rows[3] = '{"short_press_config", 2'b01, 5, 0, 0, 0};
		rows[4] = '{"long_hold", 2'b10, 60, 0, 1, 0};
		rows[5] = '{"restart_mid_sequence", 2'b10, 10, 4, 1, 0}; // second strobe lands in sync
		rows[6] = '{"both_buttons", 2'b11, 10, 0, 1, 1};
	endtask

	function automatic int row_budget(input test_row_t row);
		int presses;
		presses = (row.repress_gap > 0) ? 2 : 1;
		return 17 + presses * row.hold + row.repress_gap + quiet_cycles; // 17 is the widest gap
	endfunction

	// pulse and capture monitor sees the pins before the edge updates them
	always @(posedge clock) begin
		logic [3:0] level;
		alpha_link_pkg::serial_out_t seen;
		alpha_link_pkg::chip_pins_t expected;
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: no verdict after %0d cycles", cycle_limit);
			fail_run();
		end else if (monitoring) begin
			// shifter sclk only shows where dreset is low
			level = {pins.sclk & ~pins.pclk_t, pins.token, pins.sync, pins.pclk_t};
			for (int k = 0; k < 4; k++) begin
				if (level[k] && !prev_level[k]) begin
					rise_at[k] = cycle;
				end else if (!level[k] && prev_level[k]) begin
					pulses.push_back('{kind: k, start: rise_at[k], width: cycle - rise_at[k]});
				end
			end
			if (level[3] && !prev_level[3]) begin
				seen.sin = pins.sin;
				seen.sclk = level[3];
				captures.push_back('{at: cycle, value: seen});
			end
			prev_level = level;
			// pclk copies and auxtrig are dreset ORed in
			expected.pclk_t = pins.pclk_t;
			expected.pclk_m = pins.pclk_t;
			expected.pclk_b = pins.pclk_t;
			expected.sclk = pins.pclk_t | (!sclk_free && pins.sclk);
			expected.sin = pins.sin;
			expected.sync = pins.sync;
			expected.token = pins.token;
			expected.auxtrig = auxtrig_in | pins.pclk_t;
			check_pins({current_test, " pins"}, expected, pins);
		end
	end

	task automatic check_idle_pins();
		alpha_link_pkg::chip_pins_t expected;
		for (int value = 0; value < 2; value++) begin
			auxtrig_in = value[0];
			@(posedge clock);
			expected = '0;
			expected.auxtrig = value[0]; // only auxtrig follows its input
			check_pins("after_reset", expected, pins);
			@(negedge clock);
		end
	endtask

	task automatic press(input alpha_link_pkg::buttons_t value, input int hold);
		buttons = value;
		repeat (hold) @(negedge clock);
		buttons = '0;
	endtask

	task automatic check_sequence_pulses(input test_row_t row, input int press_at);
		int base;
		int found;
		int tokens;
		alpha_link_pkg::sequence_out_t expected;
		alpha_link_pkg::sequence_out_t actual;
		base = press_at + seq_offset;
		found = 0;
		tokens = 0;
		foreach (pulses[i]) begin
			if (pulses[i].kind == 2) begin
				tokens++; // a cut-off first run has no token
			end
			if (pulses[i].kind < 3 && pulses[i].start >= base) begin
				// dreset then sync then token with each high and then low for a phase
				expected = alpha_link_pkg::sequence_out_t'(3'b100 >> (found % 3));
				actual = alpha_link_pkg::sequence_out_t'(3'b100 >> pulses[i].kind);
				check_sequence({row.name, " order"}, expected, actual);
				check_count({row.name, " start"}, base + 2 * phase_cycles * found, pulses[i].start);
				check_count({row.name, " width"}, phase_cycles, pulses[i].width);
				found++;
			end
		end
		check_count({row.name, " pulse count"}, 3 * row.sequences, found);
		check_count({row.name, " token count"}, row.sequences, tokens);
	endtask

	task automatic check_shift(input test_row_t row, input int press_at);
		int base;
		int clocks;
		alpha_link_pkg::serial_out_t expected;
		base = press_at + shift_offset;
		clocks = 0;
		foreach (pulses[i]) begin
			if (pulses[i].kind == 3) begin
				check_count({row.name, " sclk width"}, phase_cycles, pulses[i].width);
				clocks++;
			end
		end
		check_count({row.name, " sclk count"}, shift_bits * row.shifts, clocks);
		check_count({row.name, " bit count"}, shift_bits * row.shifts, captures.size());
		foreach (captures[k]) begin
			// lsb first with the index wrapping so the tail repeats the low bits
			expected.sin = config_word[k % word_bits];
			expected.sclk = 1'b1;
			check_serial($sformatf("%s bit %0d", row.name, k), expected, captures[k].value);
			check_count({row.name, " bit time"}, base + 3 * phase_cycles * k, captures[k].at);
		end
	endtask

	task automatic run_row(input test_row_t row);
		int gap;
		int aux;
		int press_at;
		draw_random(4, gap);
		draw_random(1, aux);
		current_test = row.name;
		auxtrig_in = aux[0];
		repeat (gap + 2) @(negedge clock);
		pulses.delete();
		captures.delete();
		sclk_free = (row.shifts == 0);
		press_at = cycle; // the next rising edge samples the press
		press(row.press, row.hold);
		if (row.repress_gap > 0) begin
			repeat (row.repress_gap) @(negedge clock);
			press_at = cycle;
			press(row.press, row.hold);
		end
		repeat (quiet_cycles) @(negedge clock);
		check_sequence_pulses(row, press_at);
		check_shift(row, press_at);
	endtask

	initial begin
		reset = 1'b1;
		buttons = '0;
		auxtrig_in = 1'b0;
		load_rows();
		cycle_limit = 16 + 100; // reset, idle checks, margin
		for (int r = 0; r < num_rows; r++) begin
			cycle_limit += row_budget(rows[r]);
		end
		repeat (8) @(negedge clock);
		reset = 1'b0;
		monitoring = 1'b1;
		check_idle_pins();
		for (int r = 0; r < num_rows; r++) begin
			run_row(rows[r]);
		end
		if (UUT.props.failures != 0) begin
			$display("bound assertions failed %0d times", UUT.props.failures);
			fail_run();
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* build.f */
hw/alpha_timing_pkg.sv
hw/alpha_link_pkg.sv
hw/button_edge_detect.sv
hw/reset_sync_sequencer.sv
hw/serial_config_shifter.sv
hw/alpha_control_top.sv
testbench/alpha_control_properties.sv
testbench/alpha_control_tb.sv

/* Makefile */
# Verilator build for the readout chip start-up controller

VERILATOR ?= verilator
TOP ?= alpha_control_tb
RTL_TOP ?= alpha_control_top
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
FAIL_MSG ?= *** FAILED ***
PASS_MSG ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
